/* rtl/cpu_pkg.sv */
package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMEM_AW    = 8;
    localparam int DMEM_AW    = 8;

    // ADDI x0,x0,0
    localparam logic [XLEN-1:0] NOP_WORD = 32'h0000_0013;

    // Major opcodes of the supported subset
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_JAL, BR_JALR
    } br_kind_e;

    typedef struct packed {
        alu_op_e  alu_op;
        logic     use_imm;
        logic     use_pc;   // operand A is the PC, for the link value
        br_kind_e br_kind;
    } ex_ctrl_t;

    typedef struct packed {
        logic is_load;
        logic is_store;
    } mem_ctrl_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
    } wb_ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } pipe_d_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rs1_idx;
        logic [REG_ADDR_W-1:0] rs2_idx;
        logic [XLEN-1:0]       rs1_val;
        logic [XLEN-1:0]       rs2_val;
        logic [XLEN-1:0]       imm;
        ex_ctrl_t              ex_ctrl;
        mem_ctrl_t             mem_ctrl;
        wb_ctrl_t              wb_ctrl;
    } pipe_a_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] alu_result;
        logic [XLEN-1:0] store_data;
        mem_ctrl_t       mem_ctrl;
        wb_ctrl_t        wb_ctrl;
    } pipe_m_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] result;
        logic            is_store;
        logic [XLEN-1:0] store_addr;
        logic [XLEN-1:0] store_data;
        wb_ctrl_t        wb_ctrl;
    } pipe_w_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       value;
    } retire_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
    } store_t;

    localparam pipe_d_t FLUSH_D = '{valid: 1'b0, pc: '0, instr: NOP_WORD};
    localparam pipe_a_t FLUSH_A = '0;
    localparam pipe_m_t FLUSH_M = '0;
    localparam pipe_w_t FLUSH_W = '0;

endpackage

/* rtl/pipe_reg.sv */
`timescale 1ns/1ps

module pipe_reg #(
    parameter type    CABLE_T     = logic,
    parameter CABLE_T FLUSH_VALUE = '0
) (
    input  logic   clk,
    input  logic   i_reset,
    input  logic   i_enable,
    input  logic   i_flush,
    input  CABLE_T i_d,
    output CABLE_T o_q
);

    // Flush takes priority over a held stage
    always_ff @(posedge clk) begin
        if (i_reset || i_flush) begin
            o_q <= FLUSH_VALUE;
        end else if (i_enable) begin
            o_q <= i_d;
        end
    end

endmodule

/* rtl/decoder.sv */
`timescale 1ns/1ps

module decoder
    import cpu_pkg::*;
(
    input  logic [XLEN-1:0]       i_instr,
    output ex_ctrl_t              o_ex_ctrl,
    output mem_ctrl_t             o_mem_ctrl,
    output wb_ctrl_t              o_wb_ctrl,
    output logic [XLEN-1:0]       o_imm,
    output logic [REG_ADDR_W-1:0] o_rs1_idx,
    output logic [REG_ADDR_W-1:0] o_rs2_idx,
    output logic                  o_illegal
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm_i, imm_s, imm_b, imm_u, imm_j;
    logic                  writes_rd, uses_rs1, uses_rs2, illegal;

    assign opcode = i_instr[6:0];
    assign rd     = i_instr[11:7];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    always_comb begin
        o_ex_ctrl  = '{alu_op: ALU_ADD, use_imm: 1'b0, use_pc: 1'b0, br_kind: BR_NONE};
        o_mem_ctrl = '0;
        o_imm      = '0;
        writes_rd  = 1'b0;
        uses_rs1   = 1'b0;
        uses_rs2   = 1'b0;
        illegal    = 1'b0;
        case (opcode)
            OP_REG: begin
                writes_rd = 1'b1;
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: o_ex_ctrl.alu_op = ALU_ADD;
                    {7'h20, 3'b000}: o_ex_ctrl.alu_op = ALU_SUB;
                    {7'h00, 3'b100}: o_ex_ctrl.alu_op = ALU_XOR;
                    {7'h00, 3'b110}: o_ex_ctrl.alu_op = ALU_OR;
                    {7'h00, 3'b111}: o_ex_ctrl.alu_op = ALU_AND;
                    {7'h00, 3'b010}: o_ex_ctrl.alu_op = ALU_SLT;
                    default:         illegal = 1'b1;
                endcase
            end
            OP_IMM: begin
                writes_rd         = 1'b1;
                uses_rs1          = 1'b1;
                o_ex_ctrl.use_imm = 1'b1;
                o_imm             = imm_i;
                case (funct3)
                    3'b000:  o_ex_ctrl.alu_op = ALU_ADD;
                    3'b100:  o_ex_ctrl.alu_op = ALU_XOR;
                    3'b110:  o_ex_ctrl.alu_op = ALU_OR;
                    3'b111:  o_ex_ctrl.alu_op = ALU_AND;
                    3'b010:  o_ex_ctrl.alu_op = ALU_SLT;
                    default: illegal = 1'b1;
                endcase
            end
            OP_LUI: begin
                writes_rd         = 1'b1;
                o_ex_ctrl.alu_op  = ALU_PASS_B;
                o_ex_ctrl.use_imm = 1'b1;
                o_imm             = imm_u;
            end
            OP_LOAD: begin
                writes_rd          = 1'b1;
                uses_rs1           = 1'b1;
                o_ex_ctrl.use_imm  = 1'b1;
                o_mem_ctrl.is_load = 1'b1;
                o_imm              = imm_i;
                illegal            = (funct3 != 3'b010);
            end
            OP_STORE: begin
                uses_rs1            = 1'b1;
                uses_rs2            = 1'b1;
                o_ex_ctrl.use_imm   = 1'b1;
                o_mem_ctrl.is_store = 1'b1;
                o_imm               = imm_s;
                illegal             = (funct3 != 3'b010);
            end
            OP_BRANCH: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                o_imm    = imm_b;
                case (funct3)
                    3'b000:  o_ex_ctrl.br_kind = BR_BEQ;
                    3'b001:  o_ex_ctrl.br_kind = BR_BNE;
                    3'b100:  o_ex_ctrl.br_kind = BR_BLT;
                    default: illegal = 1'b1;
                endcase
            end
            // Jumps write PC plus 4 to rd
            OP_JAL: begin
                writes_rd         = 1'b1;
                o_ex_ctrl.use_pc  = 1'b1;
                o_ex_ctrl.br_kind = BR_JAL;
                o_imm             = imm_j;
            end
            OP_JALR: begin
                writes_rd         = 1'b1;
                uses_rs1          = 1'b1;
                o_ex_ctrl.use_pc  = 1'b1;
                o_ex_ctrl.br_kind = BR_JALR;
                o_imm             = imm_i;
                illegal           = (funct3 != 3'b000);
            end
            default: illegal = 1'b1;
        endcase

        // Nothing of an unknown word may reach state
        if (illegal) begin
            o_ex_ctrl.br_kind = BR_NONE;
            o_mem_ctrl        = '0;
            writes_rd         = 1'b0;
            uses_rs1          = 1'b0;
            uses_rs2          = 1'b0;
        end
    end

    assign o_wb_ctrl = '{we: writes_rd && (rd != '0), rd: rd};
    assign o_rs1_idx = uses_rs1 ? i_instr[19:15] : '0;
    assign o_rs2_idx = uses_rs2 ? i_instr[24:20] : '0;
    assign o_illegal = illegal;

endmodule

/* rtl/reg_bank.sv */
`timescale 1ns/1ps

module reg_bank
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_reset,
    input  logic                  i_we,
    input  logic [REG_ADDR_W-1:0] i_waddr,
    input  logic [XLEN-1:0]       i_wdata,
    input  logic [REG_ADDR_W-1:0] i_raddr_a,
    input  logic [REG_ADDR_W-1:0] i_raddr_b,
    output logic [XLEN-1:0]       o_rdata_a,
    output logic [XLEN-1:0]       o_rdata_b
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (i_reset) begin
            regs <= '{default: '0};
        end else if (i_we && (i_waddr != '0)) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // Same-cycle write is visible to decode
    assign o_rdata_a = (i_raddr_a == '0) ? '0 :
                       (i_we && (i_waddr == i_raddr_a)) ? i_wdata : regs[i_raddr_a];
    assign o_rdata_b = (i_raddr_b == '0) ? '0 :
                       (i_we && (i_waddr == i_raddr_b)) ? i_wdata : regs[i_raddr_b];

endmodule

/* rtl/alu.sv */
`timescale 1ns/1ps

module alu
    import cpu_pkg::*;
(
    input  alu_op_e         i_op,
    input  logic [XLEN-1:0] i_a,
    input  logic [XLEN-1:0] i_b,
    input  logic [XLEN-1:0] i_rs1,
    input  logic [XLEN-1:0] i_rs2,
    input  br_kind_e        i_br_kind,
    output logic [XLEN-1:0] o_result,
    output logic            o_taken
);

    always_comb begin
        case (i_op)
            ALU_SUB:    o_result = i_a - i_b;
            ALU_AND:    o_result = i_a & i_b;
            ALU_OR:     o_result = i_a | i_b;
            ALU_XOR:    o_result = i_a ^ i_b;
            ALU_SLT:    o_result = {{(XLEN-1){1'b0}}, $signed(i_a) < $signed(i_b)};
            ALU_PASS_B: o_result = i_b;
            default:    o_result = i_a + i_b;
        endcase
    end

    // Branch compare works on the register values
    always_comb begin
        case (i_br_kind)
            BR_BEQ:          o_taken = (i_rs1 == i_rs2);
            BR_BNE:          o_taken = (i_rs1 != i_rs2);
            BR_BLT:          o_taken = ($signed(i_rs1) < $signed(i_rs2));
            BR_JAL, BR_JALR: o_taken = 1'b1;
            default:         o_taken = 1'b0;
        endcase
    end

endmodule

/* rtl/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit
    import cpu_pkg::*;
(
    input  logic                  i_a_valid,
    input  logic                  i_a_is_load,
    input  logic [REG_ADDR_W-1:0] i_a_rd,
    input  logic                  i_d_valid,
    input  logic [REG_ADDR_W-1:0] i_d_rs1,
    input  logic [REG_ADDR_W-1:0] i_d_rs2,
    input  logic                  i_d_illegal,
    input  logic                  i_redirect,
    output logic                  o_enable_f,
    output logic                  o_enable_d,
    output logic                  o_flush_d,
    output logic                  o_flush_a
);

    logic load_use;

    // Load data only exists after M, so the consumer waits one cycle
    assign load_use = i_a_valid && i_a_is_load && (i_a_rd != '0) &&
                      i_d_valid && !i_d_illegal &&
                      ((i_a_rd == i_d_rs1) || (i_a_rd == i_d_rs2));

    assign o_enable_f = !load_use || i_redirect;
    assign o_enable_d = !load_use && !i_redirect;
    assign o_flush_d  = i_redirect;
    assign o_flush_a  = i_redirect || load_use || (i_d_valid && i_d_illegal);

endmodule

/* rtl/word_ram.sv */
`timescale 1ns/1ps

module word_ram
    import cpu_pkg::*;
#(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic              i_we,
    input  logic [ADDR_W-1:0] i_addr,
    input  logic [XLEN-1:0]   i_wdata,
    output logic [XLEN-1:0]   o_rdata
);

    logic [XLEN-1:0] mem [2**ADDR_W];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
    end

    // Asynchronous read
    assign o_rdata = mem[i_addr];

endmodule

/* rtl/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core
    import cpu_pkg::*;
(
    input  logic               clk,
    input  logic               i_reset,
    input  logic               i_imem_we,
    input  logic [IMEM_AW-1:0] i_imem_addr,
    input  logic [XLEN-1:0]    i_imem_wdata,
    output retire_t            o_retire,
    output store_t             o_store
);

    // Stage payloads
    pipe_d_t d_in, d_q;
    pipe_a_t a_in, a_q;
    pipe_m_t m_in, m_q;
    pipe_w_t w_in, w_q;

    // Pipeline control
    logic enable_f, enable_d, flush_d, flush_a;

    // Fetch
    logic [XLEN-1:0]    pc, next_pc, branch_target, jalr_sum;
    logic [IMEM_AW-1:0] imem_addr;
    logic [XLEN-1:0]    imem_rdata;

    // Decode
    ex_ctrl_t              dec_ex;
    mem_ctrl_t             dec_mem;
    wb_ctrl_t              dec_wb;
    logic [XLEN-1:0]       dec_imm;
    logic [REG_ADDR_W-1:0] dec_rs1, dec_rs2;
    logic                  dec_illegal;
    logic [XLEN-1:0]       rf_rs1, rf_rs2;

    // Execute
    logic            m_fwd_ok, w_fwd_ok;
    logic [XLEN-1:0] fwd_rs1, fwd_rs2, alu_a, alu_b, alu_result;
    logic            taken, redirect;

    // Memory
    logic [XLEN-1:0] dmem_rdata;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            pc <= '0;
        end else if (enable_f) begin
            pc <= next_pc;
        end
    end

    // JALR drops bit 0 of rs1 plus imm
    assign jalr_sum      = fwd_rs1 + a_q.imm;
    assign branch_target = (a_q.ex_ctrl.br_kind == BR_JALR) ? {jalr_sum[XLEN-1:1], 1'b0}
                                                            : a_q.pc + a_q.imm;
    assign next_pc       = redirect ? branch_target : pc + 32'd4;

    // Loader owns the instruction RAM port while reset is held
    assign imem_addr = i_imem_we ? i_imem_addr : pc[IMEM_AW+1:2];

    word_ram #(.ADDR_W(IMEM_AW)) imem (
        .clk     (clk),
        .i_we    (i_imem_we),
        .i_addr  (imem_addr),
        .i_wdata (i_imem_wdata),
        .o_rdata (imem_rdata)
    );

    assign d_in = '{valid: 1'b1, pc: pc, instr: imem_rdata};

    pipe_reg #(.CABLE_T(pipe_d_t), .FLUSH_VALUE(FLUSH_D)) pipe_d (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_enable (enable_d),
        .i_flush  (flush_d),
        .i_d      (d_in),
        .o_q      (d_q)
    );

    decoder dec (
        .i_instr    (d_q.instr),
        .o_ex_ctrl  (dec_ex),
        .o_mem_ctrl (dec_mem),
        .o_wb_ctrl  (dec_wb),
        .o_imm      (dec_imm),
        .o_rs1_idx  (dec_rs1),
        .o_rs2_idx  (dec_rs2),
        .o_illegal  (dec_illegal)
    );

    reg_bank regs (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_we      (w_q.valid && w_q.wb_ctrl.we),
        .i_waddr   (w_q.wb_ctrl.rd),
        .i_wdata   (w_q.result),
        .i_raddr_a (dec_rs1),
        .i_raddr_b (dec_rs2),
        .o_rdata_a (rf_rs1),
        .o_rdata_b (rf_rs2)
    );

    assign a_in = '{
        valid:    d_q.valid && !dec_illegal,
        pc:       d_q.pc,
        rs1_idx:  dec_rs1,
        rs2_idx:  dec_rs2,
        rs1_val:  rf_rs1,
        rs2_val:  rf_rs2,
        imm:      dec_imm,
        ex_ctrl:  dec_ex,
        mem_ctrl: dec_mem,
        wb_ctrl:  dec_wb
    };

    pipe_reg #(.CABLE_T(pipe_a_t), .FLUSH_VALUE(FLUSH_A)) pipe_a (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_enable (1'b1),
        .i_flush  (flush_a),
        .i_d      (a_in),
        .o_q      (a_q)
    );

    // Bypass, M first, then W; a load in M has no data yet
    assign m_fwd_ok = m_q.valid && m_q.wb_ctrl.we && (m_q.wb_ctrl.rd != '0) &&
                      !m_q.mem_ctrl.is_load;
    assign w_fwd_ok = w_q.valid && w_q.wb_ctrl.we && (w_q.wb_ctrl.rd != '0);

    assign fwd_rs1 = (m_fwd_ok && (m_q.wb_ctrl.rd == a_q.rs1_idx)) ? m_q.alu_result :
                     (w_fwd_ok && (w_q.wb_ctrl.rd == a_q.rs1_idx)) ? w_q.result :
                     a_q.rs1_val;
    assign fwd_rs2 = (m_fwd_ok && (m_q.wb_ctrl.rd == a_q.rs2_idx)) ? m_q.alu_result :
                     (w_fwd_ok && (w_q.wb_ctrl.rd == a_q.rs2_idx)) ? w_q.result :
                     a_q.rs2_val;

    // Link value is PC plus 4
    assign alu_a = a_q.ex_ctrl.use_pc ? a_q.pc : fwd_rs1;
    assign alu_b = a_q.ex_ctrl.use_pc  ? 32'd4 :
                   a_q.ex_ctrl.use_imm ? a_q.imm : fwd_rs2;

    alu ex_alu (
        .i_op      (a_q.ex_ctrl.alu_op),
        .i_a       (alu_a),
        .i_b       (alu_b),
        .i_rs1     (fwd_rs1),
        .i_rs2     (fwd_rs2),
        .i_br_kind (a_q.ex_ctrl.br_kind),
        .o_result  (alu_result),
        .o_taken   (taken)
    );

    assign redirect = a_q.valid && taken;

    hazard_unit hazard (
        .i_a_valid   (a_q.valid),
        .i_a_is_load (a_q.mem_ctrl.is_load),
        .i_a_rd      (a_q.wb_ctrl.rd),
        .i_d_valid   (d_q.valid),
        .i_d_rs1     (dec_rs1),
        .i_d_rs2     (dec_rs2),
        .i_d_illegal (dec_illegal),
        .i_redirect  (redirect),
        .o_enable_f  (enable_f),
        .o_enable_d  (enable_d),
        .o_flush_d   (flush_d),
        .o_flush_a   (flush_a)
    );

    assign m_in = '{
        valid:      a_q.valid,
        pc:         a_q.pc,
        alu_result: alu_result,
        store_data: fwd_rs2,
        mem_ctrl:   a_q.mem_ctrl,
        wb_ctrl:    a_q.wb_ctrl
    };

    pipe_reg #(.CABLE_T(pipe_m_t), .FLUSH_VALUE(FLUSH_M)) pipe_m (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_enable (1'b1),
        .i_flush  (1'b0),
        .i_d      (m_in),
        .o_q      (m_q)
    );

    word_ram #(.ADDR_W(DMEM_AW)) dmem (
        .clk     (clk),
        .i_we    (m_q.valid && m_q.mem_ctrl.is_store),
        .i_addr  (m_q.alu_result[DMEM_AW+1:2]),
        .i_wdata (m_q.store_data),
        .o_rdata (dmem_rdata)
    );

    // Writeback mux
    assign w_in = '{
        valid:      m_q.valid,
        pc:         m_q.pc,
        result:     m_q.mem_ctrl.is_load ? dmem_rdata : m_q.alu_result,
        is_store:   m_q.mem_ctrl.is_store,
        store_addr: m_q.alu_result,
        store_data: m_q.store_data,
        wb_ctrl:    m_q.wb_ctrl
    };

    pipe_reg #(.CABLE_T(pipe_w_t), .FLUSH_VALUE(FLUSH_W)) pipe_w (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_enable (1'b1),
        .i_flush  (1'b0),
        .i_d      (w_in),
        .o_q      (w_q)
    );

    // Instructions without a register write retire with value zero
    assign o_retire = '{
        valid: w_q.valid,
        pc:    w_q.pc,
        we:    w_q.wb_ctrl.we,
        rd:    w_q.wb_ctrl.rd,
        value: w_q.wb_ctrl.we ? w_q.result : '0
    };

    assign o_store = '{
        valid: w_q.valid && w_q.is_store,
        addr:  w_q.store_addr,
        data:  w_q.store_data
    };

endmodule

/* dv/cpu_core_assertions.sv */
`timescale 1ns/1ps

module cpu_core_assertions
    import cpu_pkg::*;
(
    input logic    clk,
    input logic    i_reset,
    input logic    i_flush_d,
    input logic    i_enable_d,
    input logic    i_taken,
    input logic    i_a_valid,
    input retire_t i_retire,
    input store_t  i_store
);

    // Pipe D is never loaded and flushed in the same cycle
    assert property (@(posedge clk) !(i_flush_d && i_enable_d))
        else $error("pipe D flush and enable both high");

    assert property (@(posedge clk) (i_retire.valid && i_retire.rd == '0) |-> i_retire.value == '0)
        else $error("retire with rd zero carries a nonzero value");

    // Only a live execute instruction may take a branch or jump
    assert property (@(posedge clk) i_taken |-> i_a_valid)
        else $error("redirect from an invalid execute stage");

    assert property (@(posedge clk) ($past(i_reset) || $past(i_reset, 2)) |->
                     (!i_retire.valid && !i_store.valid))
        else $error("retire or store valid around reset");

endmodule

bind cpu_core cpu_core_assertions assertions (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_flush_d  (flush_d),
    .i_enable_d (enable_d),
    .i_taken    (taken),
    .i_a_valid  (a_q.valid),
    .i_retire   (o_retire),
    .i_store    (o_store)
);

/* dv/cpu_core_tb.sv */
`timescale 1ns/1ps

module cpu_core_tb
    import cpu_pkg::*;
;

    localparam int NUM_PROGS   = 8;
    localparam int PROG_LEN    = 48;
    localparam int MEM_WORDS   = 16;
    localparam int CYCLE_LIMIT = NUM_PROGS * (PROG_LEN * 3 + 20);

    logic               clk;
    logic               i_reset;
    logic               i_imem_we;
    logic [IMEM_AW-1:0] i_imem_addr;
    logic [XLEN-1:0]    i_imem_wdata;
    retire_t            o_retire;
    store_t             o_store;

    integer seed;
    int     run_cycles;

    // Program image and the expected retire stream
    logic [31:0] prog     [PROG_LEN];
    logic [31:0] exp_pc   [PROG_LEN];
    logic        exp_we   [PROG_LEN];
    logic [4:0]  exp_rd   [PROG_LEN];
    logic [31:0] exp_val  [PROG_LEN];
    logic        exp_st   [PROG_LEN];
    logic [31:0] exp_addr [PROG_LEN];
    logic [31:0] exp_data [PROG_LEN];
    int          exp_count;

    cpu_core dut (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_imem_we    (i_imem_we),
        .i_imem_addr  (i_imem_addr),
        .i_imem_wdata (i_imem_wdata),
        .o_retire     (o_retire),
        .o_store      (o_store)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (!i_reset) begin
            run_cycles = run_cycles + 1;
        end
        if (run_cycles > CYCLE_LIMIT) begin
            $display("timeout: retire stream stalled");
            $display("TEST FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR at %0t: %s expected %h actual %h", $time, name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    function automatic logic [31:0] sext12(logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // Reference ALU where sel 0 to 5 selects add, sub, and, or, xor and slt
    function automatic logic [31:0] alu_model(int sel, logic [31:0] a, logic [31:0] b);
        case (sel)
            0:       return a + b;
            1:       return a - b;
            2:       return a & b;
            3:       return a | b;
            4:       return a ^ b;
            default: return {31'b0, $signed(a) < $signed(b)};
        endcase
    endfunction

    function automatic logic [2:0] funct3_of(int sel);
        case (sel)
            2:       return 3'b111;
            3:       return 3'b110;
            4:       return 3'b100;
            5:       return 3'b010;
            default: return 3'b000;
        endcase
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    // Generates one program and runs the ISA model alongside it
    task automatic build_program();
        logic [31:0] regs   [32];
        logic [31:0] dmodel [MEM_WORDS];
        logic        stored [MEM_WORDS];
        logic [31:0] r, r2, w, res, sdata, fb_w, fb_res, tgt_addr;
        logic [4:0]  rd, rs1, rs2, prs;
        logic [12:0] boff;
        logic [2:0]  bf3;
        int          kind, sel, pc_idx, nxt, tgt, pair_step, ptgt, widx;
        logic        exec, wr, st, legal, taken;
        regs      = '{default: '0};
        dmodel    = '{default: '0};
        stored    = '{default: 1'b0};
        pc_idx    = 0;
        pair_step = 0;
        ptgt      = 0;
        prs       = 5'd1;
        exp_count = 0;
        for (int i = 0; i < PROG_LEN; i++) begin
            exec   = (pc_idx == i);
            r      = $random(seed);
            r2     = $random(seed);
            kind   = int'(r[15:0]) % 20;
            sel    = int'(r[31:25]) % 6;
            rd     = {2'b00, r[18:16]};
            rs1    = {2'b00, r[21:19]};
            rs2    = {2'b00, r[24:22]};
            widx   = int'(r2[15:12]);
            tgt    = i + 1 + int'(r2[18:16]);
            if (tgt > PROG_LEN - 1) begin
                tgt = PROG_LEN - 1;
            end
            fb_w   = enc_i(r2[11:0], rs1, 3'b000, rd, OP_IMM);
            fb_res = regs[rs1] + sext12(r2[11:0]);
            wr     = 1'b0;
            st     = 1'b0;
            legal  = 1'b1;
            res    = '0;
            sdata  = '0;
            nxt    = i + 1;
            if (i == PROG_LEN - 1) begin
                // Final self-jump
                w   = enc_j(21'd0, 5'd0);
                rd  = 5'd0;
                nxt = i;
            end else if (pair_step == 1) begin
                w         = enc_i(12'(ptgt * 4), prs, 3'b000, prs, OP_IMM);
                rd        = prs;
                wr        = 1'b1;
                res       = regs[prs] + 32'(ptgt * 4);
                pair_step = 2;
            end else if (pair_step == 2) begin
                pair_step = 0;
                tgt_addr  = regs[prs];
                if (exec && (tgt_addr[1:0] != 2'b00 || tgt_addr <= 32'(i * 4) ||
                             tgt_addr > 32'((PROG_LEN - 1) * 4))) begin
                    // A branch skipped part of the pair
                    w   = fb_w;
                    res = fb_res;
                    wr  = 1'b1;
                end else begin
                    w   = enc_i(12'd0, prs, 3'b000, rd, OP_JALR);
                    wr  = 1'b1;
                    res = 32'(i * 4 + 4);
                    nxt = int'(tgt_addr >> 2);
                end
            end else begin
                case (kind)
                    0: begin
                        w     = {r2[31:7], 7'b1111111};
                        legal = 1'b0;
                    end
                    1, 2, 3, 18, 19: begin
                        w   = {(sel == 1) ? 7'h20 : 7'h00, rs2, rs1, funct3_of(sel), rd, OP_REG};
                        res = alu_model(sel, regs[rs1], regs[rs2]);
                        wr  = 1'b1;
                    end
                    4, 5, 6: begin
                        if (sel == 1) begin
                            sel = 0;
                        end
                        w   = enc_i(r2[11:0], rs1, funct3_of(sel), rd, OP_IMM);
                        res = alu_model(sel, regs[rs1], sext12(r2[11:0]));
                        wr  = 1'b1;
                    end
                    7: begin
                        w   = {r2[31:12], rd, OP_LUI};
                        res = {r2[31:12], 12'b0};
                        wr  = 1'b1;
                    end
                    8, 9: begin
                        wr = 1'b1;
                        if (stored[widx] || !exec) begin
                            w   = enc_i(12'(widx * 4), 5'd0, 3'b010, rd, OP_LOAD);
                            res = dmodel[widx];
                        end else begin
                            w   = fb_w;
                            res = fb_res;
                        end
                    end
                    10, 11: begin
                        w     = {7'((widx * 4) >> 5), rs2, 5'd0, 3'b010, 5'(widx * 4), OP_STORE};
                        st    = 1'b1;
                        sdata = regs[rs2];
                    end
                    12, 13, 14: begin
                        boff = 13'((tgt - i) * 4);
                        case (sel % 3)
                            0: begin
                                bf3   = 3'b000;
                                taken = (regs[rs1] == regs[rs2]);
                            end
                            1: begin
                                bf3   = 3'b001;
                                taken = (regs[rs1] != regs[rs2]);
                            end
                            default: begin
                                bf3   = 3'b100;
                                taken = ($signed(regs[rs1]) < $signed(regs[rs2]));
                            end
                        endcase
                        w   = {boff[12], boff[10:5], rs2, rs1, bf3,
                               boff[4:1], boff[11], OP_BRANCH};
                        nxt = taken ? tgt : i + 1;
                    end
                    15: begin
                        w   = enc_j(21'((tgt - i) * 4), rd);
                        wr  = 1'b1;
                        res = 32'(i * 4 + 4);
                        nxt = tgt;
                    end
                    default: begin
                        wr = 1'b1;
                        if (i + 2 <= PROG_LEN - 3) begin
                            // LUI, ADDI, then JALR through prs
                            prs  = 5'(1 + int'(r[18:16]) % 7);
                            ptgt = i + 3 + int'(r2[18:16]);
                            if (ptgt > PROG_LEN - 1) begin
                                ptgt = PROG_LEN - 1;
                            end
                            w         = {20'd0, prs, OP_LUI};
                            rd        = prs;
                            pair_step = 1;
                        end else begin
                            w   = fb_w;
                            res = fb_res;
                        end
                    end
                endcase
            end
            prog[i] = w;
            if (exec) begin
                if (legal) begin
                    exp_pc[exp_count]   = 32'(i * 4);
                    exp_we[exp_count]   = wr && (rd != 5'd0);
                    exp_rd[exp_count]   = rd;
                    exp_val[exp_count]  = (wr && (rd != 5'd0)) ? res : 32'd0;
                    exp_st[exp_count]   = st;
                    exp_addr[exp_count] = 32'(widx * 4);
                    exp_data[exp_count] = sdata;
                    exp_count++;
                    if (wr && (rd != 5'd0)) begin
                        regs[rd] = res;
                    end
                    if (st) begin
                        stored[widx] = 1'b1;
                        dmodel[widx] = sdata;
                    end
                end
                pc_idx = nxt;
            end
        end
    endtask

    task automatic run_program();
        int idx;
        int k;
        @(posedge clk);
        i_reset <= 1'b1;
        for (k = 0; k < PROG_LEN; k++) begin
            @(posedge clk);
            i_imem_we    <= 1'b1;
            i_imem_addr  <= IMEM_AW'(k);
            i_imem_wdata <= prog[k];
        end
        repeat (4) begin
            @(posedge clk);
            i_imem_we <= 1'b0;
        end
        @(posedge clk);
        i_reset <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_value("o_retire.valid", 32'd0, 32'(o_retire.valid));
            check_value("o_store.valid", 32'd0, 32'(o_store.valid));
        end
        idx = 0;
        while (idx < exp_count) begin
            @(negedge clk);
            if (o_retire.valid) begin
                check_value("o_retire.pc", exp_pc[idx], o_retire.pc);
                check_value("o_retire.we", 32'(exp_we[idx]), 32'(o_retire.we));
                if (exp_we[idx]) begin
                    check_value("o_retire.rd", 32'(exp_rd[idx]), 32'(o_retire.rd));
                end
                check_value("o_retire.value", exp_val[idx], o_retire.value);
                check_value("o_store.valid", 32'(exp_st[idx]), 32'(o_store.valid));
                if (exp_st[idx]) begin
                    check_value("o_store.addr", exp_addr[idx], o_store.addr);
                    check_value("o_store.data", exp_data[idx], o_store.data);
                end
                idx++;
            end else begin
                check_value("o_store.valid", 32'd0, 32'(o_store.valid));
            end
        end
    endtask

    initial begin
        seed         = 32'hf7c6;
        run_cycles   = 0;
        clk          = 1'b0;
        i_reset      = 1'b1;
        i_imem_we    = 1'b0;
        i_imem_addr  = '0;
        i_imem_wdata = '0;
        for (int p = 0; p < NUM_PROGS; p++) begin
            build_program();
            run_program();
        end
        $display("TEST OK");
        $finish;
    end

endmodule

/* cpu_core.f */
rtl/cpu_pkg.sv
rtl/pipe_reg.sv
rtl/decoder.sv
rtl/reg_bank.sv
rtl/alu.sv
rtl/hazard_unit.sv
rtl/word_ram.sv
rtl/cpu_core.sv
dv/cpu_core_assertions.sv
dv/cpu_core_tb.sv

/* Makefile */
TOP       ?= cpu_core_tb
SEED      ?= 0
VERILATOR ?= verilator
LOG       ?= sim.log

FILELIST := cpu_core.f
SRCS     := $(shell grep -v '^+' $(FILELIST))
DV_SRCS  := $(wildcard dv/*)
SIM      := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(FILELIST) $(SRCS) $(DV_SRCS)
	$(VERILATOR) --binary --assert -f $(FILELIST) --top-module $(TOP) -o V$(TOP)

run: $(SIM)
	./$(SIM) +verilator+seed+$(SEED) 2>&1 | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
